/* Bender.yml */
package:
  name: ppu_vram

sources:
  # RTL in compile order.
  - files:
      - hdl/ppu_vram_pkg.sv
      - hdl/vram_bank.sv
      - hdl/vram_host_port.sv
      - hdl/ppu_debug_reader.sv
      - hdl/ppu_vram_top.sv
  # verification sources.
  - target: simulation
    files:
      - verif/ppu_vram_asserts.sv
      - verif/tb_ppu_vram.sv

/* hdl/ppu_debug_reader.sv */
/*
  Debug reader. Watches the first and last entry of the tile, pattern
  and sprite RAMs for the magic value and serves palette reads.
*/
`timescale 1ns/10ps

module ppu_debug_reader (
    input  logic                                 clk,
    input  logic                                 rst_n,
    output logic [5:0]                           led,
    input  logic [ppu_vram_pkg::palram_addr_w-1:0] palram_rdaddr,
    output logic [ppu_vram_pkg::vram_data_w-1:0] palram_rddata,
    output ppu_vram_pkg::vram_req_t              til_a,
    output ppu_vram_pkg::vram_req_t              pat_a,
    output ppu_vram_pkg::vram_req_t              spr_a,
    output ppu_vram_pkg::vram_req_t              pal_a,
    output ppu_vram_pkg::vram_req_t              watch_til_b,
    output ppu_vram_pkg::vram_req_t              watch_pat_b,
    output ppu_vram_pkg::vram_req_t              watch_spr_b,
    input  logic [ppu_vram_pkg::vram_data_w-1:0] til_rd_a,
    input  logic [ppu_vram_pkg::vram_data_w-1:0] til_rd_b,
    input  logic [ppu_vram_pkg::vram_data_w-1:0] pat_rd_a,
    input  logic [ppu_vram_pkg::vram_data_w-1:0] pat_rd_b,
    input  logic [ppu_vram_pkg::vram_data_w-1:0] spr_rd_a,
    input  logic [ppu_vram_pkg::vram_data_w-1:0] spr_rd_b,
    input  logic [ppu_vram_pkg::vram_data_w-1:0] pal_rd_a,
    input  logic                                 til_rdvalid_b,
    input  logic                                 pat_rdvalid_b,
    input  logic                                 spr_rdvalid_b
);

    logic [5:0] watch_hit;
    logic [5:0] flags;

    // port A of the watched banks reads entry 0 forever.
    always_comb begin
        til_a = '0;
        pat_a = '0;
        spr_a = '0;
    end

    // port B watches the last entry of each bank.
    always_comb begin
        watch_til_b      = '0;
        watch_pat_b      = '0;
        watch_spr_b      = '0;
        watch_til_b.addr = ppu_vram_pkg::tilram_last;
        watch_pat_b.addr = ppu_vram_pkg::patram_last;
        watch_spr_b.addr = ppu_vram_pkg::sprram_last;
    end

    // the palette read port belongs to the display side.
    always_comb begin
        pal_a      = '0;
        pal_a.addr = {{(ppu_vram_pkg::vram_addr_w - ppu_vram_pkg::palram_addr_w){1'b0}},
                      palram_rdaddr};
    end

    assign palram_rddata = pal_rd_a; // registered inside the bank.

    // port-B data may be a write cycle's leftover, hence the valid qualifier.
    assign watch_hit[0] = (til_rd_a == ppu_vram_pkg::watch_magic);
    assign watch_hit[1] = til_rdvalid_b && (til_rd_b == ppu_vram_pkg::watch_magic);
    assign watch_hit[2] = (pat_rd_a == ppu_vram_pkg::watch_magic);
    assign watch_hit[3] = pat_rdvalid_b && (pat_rd_b == ppu_vram_pkg::watch_magic);
    assign watch_hit[4] = (spr_rd_a == ppu_vram_pkg::watch_magic);
    assign watch_hit[5] = spr_rdvalid_b && (spr_rd_b == ppu_vram_pkg::watch_magic);

    // flags are sticky. once a location has held the magic value it stays lit.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else begin
            flags <= flags | watch_hit;
        end
    end

    assign led = flags;

endmodule : ppu_debug_reader

/* hdl/ppu_vram_pkg.sv */
/*
  Shared widths, bank depths, watch constants, the bank identifier
  and the request structs of the video-RAM subsystem.
*/
package ppu_vram_pkg;

    // word geometry of every bank.
    localparam int unsigned vram_data_w = 64;
    localparam int unsigned vram_be_w   = vram_data_w / 8;
    localparam int unsigned vram_addr_w = 12; // pattern RAM needs the most bits.

    // number of entries per bank.
    localparam int unsigned tilram_depth = 2048;
    localparam int unsigned patram_depth = 4096;
    localparam int unsigned sprram_depth = 40;
    localparam int unsigned palram_depth = 512;

    localparam int unsigned palram_addr_w = 9;

    // last entry of each watched bank, where port B keeps its watch.
    localparam logic [vram_addr_w-1:0] tilram_last = vram_addr_w'(tilram_depth - 1);
    localparam logic [vram_addr_w-1:0] patram_last = vram_addr_w'(patram_depth - 1);
    localparam logic [vram_addr_w-1:0] sprram_last = vram_addr_w'(sprram_depth - 1);

    // a watched word holding this value lights its LED.
    localparam logic [vram_data_w-1:0] watch_magic = 64'd12345;

    typedef enum logic [1:0] {
        bank_til,
        bank_pat,
        bank_spr,
        bank_pal
    } vram_bank_e;

    // one memory port request; a read is a request with wren low.
    typedef struct packed {
        logic [vram_addr_w-1:0] addr;
        logic                   wren;
        logic [vram_data_w-1:0] wrdata;
        logic [vram_be_w-1:0]   byteena;
    } vram_req_t;

    // a host write names the bank and an offset inside it.
    typedef struct packed {
        vram_bank_e             bank;
        logic [vram_addr_w-1:0] offset;
        logic [vram_data_w-1:0] data;
        logic [vram_be_w-1:0]   byteena;
    } host_wr_t;

endpackage : ppu_vram_pkg

/* hdl/ppu_vram_top.sv */
/*
  Video-RAM subsystem top level with four dual-port banks, the host
  write decoder and the debug reader.
*/
`timescale 1ns/10ps

module ppu_vram_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   host_wr,
    input  ppu_vram_pkg::host_wr_t                 host_req,
    input  logic [ppu_vram_pkg::palram_addr_w-1:0] palram_rdaddr,
    output logic [ppu_vram_pkg::vram_data_w-1:0]   palram_rddata,
    output logic [5:0]                             led
);

    // port-A requests from the reader.
    ppu_vram_pkg::vram_req_t til_a;
    ppu_vram_pkg::vram_req_t pat_a;
    ppu_vram_pkg::vram_req_t spr_a;
    ppu_vram_pkg::vram_req_t pal_a;

    // watch requests, reader to host port.
    ppu_vram_pkg::vram_req_t watch_til_b;
    ppu_vram_pkg::vram_req_t watch_pat_b;
    ppu_vram_pkg::vram_req_t watch_spr_b;

    // port-B requests, host port to banks.
    ppu_vram_pkg::vram_req_t til_b;
    ppu_vram_pkg::vram_req_t pat_b;
    ppu_vram_pkg::vram_req_t spr_b;
    ppu_vram_pkg::vram_req_t pal_b;

    logic [ppu_vram_pkg::vram_data_w-1:0] til_rd_a;
    logic [ppu_vram_pkg::vram_data_w-1:0] til_rd_b;
    logic [ppu_vram_pkg::vram_data_w-1:0] pat_rd_a;
    logic [ppu_vram_pkg::vram_data_w-1:0] pat_rd_b;
    logic [ppu_vram_pkg::vram_data_w-1:0] spr_rd_a;
    logic [ppu_vram_pkg::vram_data_w-1:0] spr_rd_b;
    logic [ppu_vram_pkg::vram_data_w-1:0] pal_rd_a;

    logic til_rdvalid_b;
    logic pat_rdvalid_b;
    logic spr_rdvalid_b;

    vram_bank #(.DEPTH(ppu_vram_pkg::tilram_depth)) tilram_bank (
        .clk,
        .rst_n,
        .req_a     (til_a),
        .req_b     (til_b),
        .rddata_a  (til_rd_a),
        .rddata_b  (til_rd_b),
        .rdvalid_b (til_rdvalid_b)
    );

    vram_bank #(.DEPTH(ppu_vram_pkg::patram_depth)) patram_bank (
        .clk,
        .rst_n,
        .req_a     (pat_a),
        .req_b     (pat_b),
        .rddata_a  (pat_rd_a),
        .rddata_b  (pat_rd_b),
        .rdvalid_b (pat_rdvalid_b)
    );

    vram_bank #(.DEPTH(ppu_vram_pkg::sprram_depth)) sprram_bank (
        .clk,
        .rst_n,
        .req_a     (spr_a),
        .req_b     (spr_b),
        .rddata_a  (spr_rd_a),
        .rddata_b  (spr_rd_b),
        .rdvalid_b (spr_rdvalid_b)
    );

    // palette port B only takes host writes, its read side is left open.
    vram_bank #(.DEPTH(ppu_vram_pkg::palram_depth)) palram_bank (
        .clk,
        .rst_n,
        .req_a     (pal_a),
        .req_b     (pal_b),
        .rddata_a  (pal_rd_a),
        .rddata_b  (),
        .rdvalid_b ()
    );

    vram_host_port i_vram_host_port (
        .host_wr,
        .host_req,
        .watch_til_b,
        .watch_pat_b,
        .watch_spr_b,
        .til_b,
        .pat_b,
        .spr_b,
        .pal_b
    );

    ppu_debug_reader i_ppu_debug_reader (
        .clk,
        .rst_n,
        .led,
        .palram_rdaddr,
        .palram_rddata,
        .til_a,
        .pat_a,
        .spr_a,
        .pal_a,
        .watch_til_b,
        .watch_pat_b,
        .watch_spr_b,
        .til_rd_a,
        .til_rd_b,
        .pat_rd_a,
        .pat_rd_b,
        .spr_rd_a,
        .spr_rd_b,
        .pal_rd_a,
        .til_rdvalid_b,
        .pat_rdvalid_b,
        .spr_rdvalid_b
    );

endmodule : ppu_vram_top

/* hdl/vram_bank.sv */
/*
  True dual-port 64-bit memory with byte-enabled writes, registered
  reads on both ports and a read-valid flag for port B.
*/
`timescale 1ns/10ps

module vram_bank #(
    parameter int unsigned DEPTH = 2048
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  ppu_vram_pkg::vram_req_t       req_a,
    input  ppu_vram_pkg::vram_req_t       req_b,
    output logic [ppu_vram_pkg::vram_data_w-1:0] rddata_a,
    output logic [ppu_vram_pkg::vram_data_w-1:0] rddata_b,
    output logic                          rdvalid_b
);

    logic [ppu_vram_pkg::vram_data_w-1:0] mem [DEPTH];

    // only the low address bits that reach DEPTH are decoded.
    logic [$clog2(DEPTH)-1:0] addr_a;
    logic [$clog2(DEPTH)-1:0] addr_b;

    assign addr_a = req_a.addr[$clog2(DEPTH)-1:0];
    assign addr_b = req_b.addr[$clog2(DEPTH)-1:0];

    // both ports write byte lanes here; port B is applied last and so wins a collision.
    always_ff @(posedge clk) begin
        if (req_a.wren && addr_a < DEPTH) begin
            for (int i = 0; i < ppu_vram_pkg::vram_be_w; i++) begin
                if (req_a.byteena[i]) begin
                    mem[addr_a][8*i +: 8] <= req_a.wrdata[8*i +: 8];
                end
            end
        end
        if (req_b.wren && addr_b < DEPTH) begin
            for (int i = 0; i < ppu_vram_pkg::vram_be_w; i++) begin
                if (req_b.byteena[i]) begin
                    mem[addr_b][8*i +: 8] <= req_b.wrdata[8*i +: 8];
                end
            end
        end
        rddata_a <= mem[addr_a]; // read-first, new data shows a cycle later.
        rddata_b <= mem[addr_b];
    end

    // port B data counts as a read only after a cycle in which it did not write.
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rdvalid_b <= 1'b0;
        end else begin
            rdvalid_b <= !req_b.wren;
        end
    end

endmodule : vram_bank

/* hdl/vram_host_port.sv */
/*
  Host write decoder. Turns a host write into a port-B request for one
  bank and otherwise lets the debug reader's watch requests through.
*/
`timescale 1ns/10ps

module vram_host_port (
    input  logic                    host_wr,
    input  ppu_vram_pkg::host_wr_t  host_req,
    input  ppu_vram_pkg::vram_req_t watch_til_b,
    input  ppu_vram_pkg::vram_req_t watch_pat_b,
    input  ppu_vram_pkg::vram_req_t watch_spr_b,
    output ppu_vram_pkg::vram_req_t til_b,
    output ppu_vram_pkg::vram_req_t pat_b,
    output ppu_vram_pkg::vram_req_t spr_b,
    output ppu_vram_pkg::vram_req_t pal_b
);

    ppu_vram_pkg::vram_req_t wr_req;

    logic til_hit;
    logic pat_hit;
    logic spr_hit;
    logic pal_hit;

    // a write hits a bank only when it is selected and the offset fits its depth.
    function automatic logic bank_hit(
        input logic                    wr,
        input ppu_vram_pkg::host_wr_t  req,
        input ppu_vram_pkg::vram_bank_e bank,
        input int unsigned             depth
    );
        return wr && (req.bank == bank) && (req.offset < depth);
    endfunction

    assign til_hit = bank_hit(host_wr, host_req, ppu_vram_pkg::bank_til,
                              ppu_vram_pkg::tilram_depth);
    assign pat_hit = bank_hit(host_wr, host_req, ppu_vram_pkg::bank_pat,
                              ppu_vram_pkg::patram_depth);
    assign spr_hit = bank_hit(host_wr, host_req, ppu_vram_pkg::bank_spr,
                              ppu_vram_pkg::sprram_depth);
    assign pal_hit = bank_hit(host_wr, host_req, ppu_vram_pkg::bank_pal,
                              ppu_vram_pkg::palram_depth);

    // the same write word goes to whichever bank is hit.
    always_comb begin
        wr_req         = '0;
        wr_req.addr    = host_req.offset;
        wr_req.wren    = 1'b1;
        wr_req.wrdata  = host_req.data;
        wr_req.byteena = host_req.byteena;
    end

    /*
      A write only displaces the watch of the bank it lands in. The other
      watched banks keep reading their last entry, so port-B read data
      never comes from an address other than the watched one.
    */
    assign til_b = til_hit ? wr_req : watch_til_b;
    assign pat_b = pat_hit ? wr_req : watch_pat_b;
    assign spr_b = spr_hit ? wr_req : watch_spr_b;
    assign pal_b = pal_hit ? wr_req : '0; // palette port B has no watch and idles.

endmodule : vram_host_port

/* verif/ppu_vram_asserts.sv */
/*
  Concurrent assertions on the video-RAM top level, bound into it.
*/
`timescale 1ns/10ps

module ppu_vram_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   host_wr,
    input ppu_vram_pkg::host_wr_t host_req,
    input logic [8:0]             palram_rdaddr,
    input logic [63:0]            palram_rddata,
    input logic [5:0]             led
);

    logic pal_write_hit;

    // a palette write to the address that the display side is reading.
    assign pal_write_hit = host_wr && host_req.bank == ppu_vram_pkg::bank_pal &&
                           host_req.offset == {3'b000, palram_rdaddr};

    led_zero_in_reset: assert property (@(posedge clk) !rst_n |-> led == '0)
        else $error("led is not zero while reset is held");

    // flags are sticky, a known bit that was set never drops.
    led_never_falls: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown($past(led)) |-> ($past(led) & ~led) == '0)
        else $error("a led bit fell outside reset");

    pal_read_known: assert property (@(posedge clk) disable iff (!rst_n)
        (pal_write_hit ##1 $stable(palram_rdaddr)) |=> !$isunknown(palram_rddata))
        else $error("palette read data unknown after a write to the same address");

endmodule : ppu_vram_asserts

bind ppu_vram_top ppu_vram_asserts i_ppu_vram_asserts (.*);

/* verif/tb_ppu_vram.sv */
/*
  Testbench for the video-RAM subsystem with random host writes from a
  fixed seed, a model of the palette and watched words, and led checks.
*/
`timescale 1ns/10ps

module tb_ppu_vram;

    logic                   clk;
    logic                   rst_n;
    logic                   host_wr;
    ppu_vram_pkg::host_wr_t host_req;
    logic [8:0]             palram_rdaddr;
    logic [63:0]            palram_rddata;
    logic [5:0]             led;

    logic [63:0] pal_model [ppu_vram_pkg::palram_depth];
    logic [63:0] watch_model [6]; // indexed like the led bits.
    bit [ppu_vram_pkg::palram_depth-1:0] pal_known;
    int unsigned pal_written [$];
    logic [5:0]  exp_led;
    int seed = 32'h4dc9_73b9;
    int checks;
    int errors;
    int tests;
    int test_errors;

    ppu_vram_top i_ppu_vram_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_wr       (host_wr),
        .host_req      (host_req),
        .palram_rdaddr (palram_rdaddr),
        .palram_rddata (palram_rddata),
        .led           (led)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic int unsigned depth_of(ppu_vram_pkg::vram_bank_e bank);
        case (bank)
            ppu_vram_pkg::bank_til: return ppu_vram_pkg::tilram_depth;
            ppu_vram_pkg::bank_pat: return ppu_vram_pkg::patram_depth;
            ppu_vram_pkg::bank_spr: return ppu_vram_pkg::sprram_depth;
            default:                return ppu_vram_pkg::palram_depth;
        endcase
    endfunction

    // watched slots are offset 0 (even bit) and the last entry (odd bit).
    function automatic int watch_slot(ppu_vram_pkg::vram_bank_e bank, int unsigned off);
        if (bank == ppu_vram_pkg::bank_pal) begin
            return -1;
        end
        if (off == 0) begin
            return 2 * int'(bank);
        end
        if (off == depth_of(bank) - 1) begin
            return 2 * int'(bank) + 1;
        end
        return -1;
    endfunction

    function automatic int unsigned slot_offset(int slot);
        return (slot % 2 == 1) ? depth_of(ppu_vram_pkg::vram_bank_e'(slot / 2)) - 1 : 0;
    endfunction

    function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] data,
                                                logic [7:0] be);
        logic [63:0] res;
        res = old;
        for (int i = 0; i < 8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic void model_write(ppu_vram_pkg::vram_bank_e bank, int unsigned off,
                                        logic [63:0] data, logic [7:0] be);
        int slot;
        if (off >= depth_of(bank)) begin
            return; // nothing is stored past the end of the bank.
        end
        if (bank == ppu_vram_pkg::bank_pal) begin
            pal_model[off] = merge_bytes(pal_model[off], data, be);
        end
        slot = watch_slot(bank, off);
        if (slot >= 0) begin
            watch_model[slot] = merge_bytes(watch_model[slot], data, be);
        end
    endfunction

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [63:0] non_magic();
        logic [63:0] d;
        d = rand64();
        if (d == ppu_vram_pkg::watch_magic) begin
            d[63] = 1'b1;
        end
        return d;
    endfunction

    function automatic void note_magic(int slot);
        if (watch_model[slot] === ppu_vram_pkg::watch_magic) begin
            exp_led[slot] = 1'b1; // flags are sticky and only reset clears them.
        end
    endfunction

    task automatic write_cycle(input ppu_vram_pkg::vram_bank_e bank, input int unsigned off,
                               input logic [63:0] data, input logic [7:0] be);
        host_wr          = 1'b1;
        host_req.bank    = bank;
        host_req.offset  = off[11:0];
        host_req.data    = data;
        host_req.byteena = be;
        model_write(bank, off, data, be);
        @(negedge clk);
    endtask

    task automatic apply_reset();
        host_wr = 1'b0;
        rst_n   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n   = 1'b1;
        exp_led = '0;
    endtask

    task automatic check_led();
        checks++;
        if (led !== exp_led) begin
            $display("CHECK FAILED at %0t: led = %b, expected %b", $time, led, exp_led);
            errors++;
        end
    endtask

    task automatic hold_led(input int cycles);
        host_wr = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            check_led();
        end
    endtask

    task automatic wait_led(input int max_cycles);
        int n;
        n = 0;
        host_wr = 1'b0;
        while (led !== exp_led && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (led !== exp_led) begin
            $display("timeout at %0t: led stayed %b and did not reach %b within %0d cycles",
                     $time, led, exp_led, max_cycles);
            errors++;
        end
    endtask

    // one cycle of read latency, so the sample is taken one edge later.
    task automatic check_pal_read(input int unsigned addr);
        host_wr       = 1'b0;
        palram_rdaddr = addr[8:0];
        @(negedge clk);
        checks++;
        if (palram_rddata !== pal_model[addr]) begin
            $display("CHECK FAILED at %0t: palram_rddata = %h, expected %h", $time,
                     palram_rddata, pal_model[addr]);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [7:0] be;
        int unsigned off;
        rst_n = 1'b1;
        host_wr = 1'b0;
        host_req = '0;
        palram_rdaddr = '0;
        exp_led = '0;
        checks = 0;
        errors = 0;
        tests = 0;
        test_errors = 0;
        // memories have no reset, so the watched words get known data first.
        @(negedge clk);
        for (int s = 0; s < 6; s++) begin
            write_cycle(ppu_vram_pkg::vram_bank_e'(s / 2), slot_offset(s), non_magic(), 8'hff);
        end
        apply_reset();

        hold_led(2);
        for (int i = 0; i < 12; i++) begin
            write_cycle(ppu_vram_pkg::vram_bank_e'((i % 6) / 2), slot_offset(i % 6),
                        non_magic(), 8'hff);
        end
        hold_led(3);
        report_test("quiet after reset");

        for (int i = 0; i < 40; i++) begin
            off = {$random(seed)} % ppu_vram_pkg::palram_depth;
            be  = $random(seed);
            if (!pal_known[off] || i % 4 == 0) begin
                be = 8'hff; // an entry's first write fills all bytes.
            end
            pal_known[off] = 1'b1;
            pal_written.push_back(off);
            palram_rdaddr = off[8:0]; // the display side reads the entry being written.
            write_cycle(ppu_vram_pkg::bank_pal, off, rand64(), be);
            check_pal_read(off);
            check_pal_read(pal_written[{$random(seed)} % pal_written.size()]);
        end
        report_test("palette round trip");

        write_cycle(ppu_vram_pkg::bank_spr, 2 * ppu_vram_pkg::sprram_depth - 1,
                    ppu_vram_pkg::watch_magic, 8'hff);
        for (int i = 0; i < 4; i++) begin
            // these offsets share their low six address bits with the watched last entry.
            off = 64 * (1 + {$random(seed)} % 63) + ppu_vram_pkg::sprram_depth - 1;
            write_cycle(ppu_vram_pkg::bank_spr, off, ppu_vram_pkg::watch_magic, 8'hff);
        end
        hold_led(3);
        report_test("sprite offset out of range");

        // top byte first so no intermediate word equals the magic value.
        write_cycle(ppu_vram_pkg::bank_til, 0, 64'hff00_0000_0000_0000, 8'h80);
        write_cycle(ppu_vram_pkg::bank_til, 0, ppu_vram_pkg::watch_magic, 8'h03);
        hold_led(3);
        write_cycle(ppu_vram_pkg::bank_til, 0, ppu_vram_pkg::watch_magic, 8'h7c);
        hold_led(3);
        write_cycle(ppu_vram_pkg::bank_til, 0, ppu_vram_pkg::watch_magic, 8'h80);
        note_magic(0);
        wait_led(2);
        write_cycle(ppu_vram_pkg::bank_til, 0, non_magic(), 8'hff);
        hold_led(3);
        report_test("partial byte build");

        // a reset clears the sticky flags while the memories keep their contents.
        apply_reset();
        hold_led(2);
        for (int b = 0; b < 3; b++) begin
            write_cycle(ppu_vram_pkg::vram_bank_e'(b), 0, ppu_vram_pkg::watch_magic, 8'hff);
            note_magic(2 * b);
            wait_led(2);
        end
        report_test("port A magic");

        for (int b = 0; b < 3; b++) begin
            write_cycle(ppu_vram_pkg::vram_bank_e'(b), slot_offset(2 * b + 1),
                        ppu_vram_pkg::watch_magic, 8'hff);
            check_led();
            for (int k = 0; k < 4; k++) begin
                off = 1 + {$random(seed)} % (depth_of(ppu_vram_pkg::vram_bank_e'(b)) - 2);
                write_cycle(ppu_vram_pkg::vram_bank_e'(b), off, non_magic(), 8'hff);
                check_led(); // port B is busy, so its flag stays low.
            end
            note_magic(2 * b + 1);
            wait_led(2);
        end
        report_test("port B magic after burst");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_ppu_vram

/* verilog.f */
hdl/ppu_vram_pkg.sv
hdl/vram_bank.sv
hdl/vram_host_port.sv
hdl/ppu_debug_reader.sv
hdl/ppu_vram_top.sv
verif/ppu_vram_asserts.sv
verif/tb_ppu_vram.sv
